/* source/eeprom_pkg.sv */
package eeprom_pkg;

    typedef logic [10:0] eeprom_addr_t;   // byte address inside the 2K array
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  apb_addr_t;

    typedef enum logic [2:0] {
        CMD_START,
        CMD_RESTART,
        CMD_WRITE,
        CMD_READ_NACK,
        CMD_STOP
    } i2c_cmd_t;

    typedef enum logic [3:0] {
        IDLE, START, CTRL_W, ADDR, DATA_W, RESTART, CTRL_R, DATA_R, STOP, FINISH
    } ctrl_state_t;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;   // 24Cxx device type
    localparam int SCL_QUARTER = 4;                 // cycles per quarter of SCL

    // register offsets
    localparam apb_addr_t REG_ADDR   = 4'h0;
    localparam apb_addr_t REG_DATA   = 4'h4;
    localparam apb_addr_t REG_CMD    = 4'h8;
    localparam apb_addr_t REG_STATUS = 4'hC;

endpackage

/* source/eeprom_ifs.sv */
`timescale 1ns/10ps

// register file to transaction controller
interface reg_ctl_if;
    import eeprom_pkg::*;

    logic         start_wr;    // one-cycle pulse
    logic         start_rd;    // one-cycle pulse
    eeprom_addr_t addr;
    byte_t        wdata;
    logic         busy;
    logic         finish;      // one-cycle pulse, rdata valid here
    logic         nack_seen;
    byte_t        rdata;

    modport regs (output start_wr, start_rd, addr, wdata,
                  input  busy, finish, nack_seen, rdata);
    modport ctrl (input  start_wr, start_rd, addr, wdata,
                  output busy, finish, nack_seen, rdata);
endinterface

// controller to bit engine, valid held until cmd_done
interface i2c_cmd_if;
    import eeprom_pkg::*;

    i2c_cmd_t cmd;
    logic     cmd_valid;
    byte_t    tx_byte;
    logic     cmd_done;
    byte_t    rx_byte;
    logic     ack_ok;      // for CMD_WRITE, valid with cmd_done

    modport master (output cmd, cmd_valid, tx_byte,
                    input  cmd_done, rx_byte, ack_ok);
    modport engine (input  cmd, cmd_valid, tx_byte,
                    output cmd_done, rx_byte, ack_ok);
endinterface

/* source/apb_regs.sv */
`timescale 1ns/10ps

module apb_regs (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eeprom_pkg::apb_addr_t paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    reg_ctl_if.regs               ctl
);
    import eeprom_pkg::*;

    eeprom_addr_t addr_q;
    byte_t        wdata_q;
    byte_t        data_q;      // value returned on REG_DATA reads
    logic         done_q;
    logic         nack_q;
    logic         rd_op;       // transaction in flight is a read
    logic         access;
    logic         known;
    logic         cmd_wr;
    logic         cmd_ok;

    assign access = psel && penable;
    assign known  = paddr inside {REG_ADDR, REG_DATA, REG_CMD, REG_STATUS};
    assign cmd_wr = access && pwrite && (paddr == REG_CMD);
    assign cmd_ok = cmd_wr && !ctl.busy;

    assign pready  = 1'b1;
    assign pslverr = access && (!known || (cmd_wr && ctl.busy));

    // write wins over read
    assign ctl.start_wr = cmd_ok && pwdata[0];
    assign ctl.start_rd = cmd_ok && !pwdata[0] && pwdata[1];
    assign ctl.addr     = addr_q;
    assign ctl.wdata    = wdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            done_q <= 1'b0;
            nack_q <= 1'b0;
            rd_op  <= 1'b0;
        end
        else if (ctl.start_wr || ctl.start_rd)
        begin
            done_q <= 1'b0;
            nack_q <= 1'b0;
            rd_op  <= ctl.start_rd;
        end
        else if (ctl.finish)
        begin
            done_q <= 1'b1;   // sticky until next command
            nack_q <= ctl.nack_seen;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (access && pwrite && (paddr == REG_ADDR))
            addr_q <= pwdata[10:0];
        if (access && pwrite && (paddr == REG_DATA))
        begin
            wdata_q <= pwdata[7:0];
            data_q  <= pwdata[7:0];
        end
        else if (ctl.finish && rd_op)
            data_q <= ctl.rdata;   // byte fetched from the EEPROM
    end

    always_comb
    begin
        prdata = '0;
        case (paddr)
            REG_ADDR:   prdata[10:0] = addr_q;
            REG_DATA:   prdata[7:0]  = data_q;
            REG_STATUS: prdata[2:0]  = {nack_q, done_q, ctl.busy};
            default:    prdata = '0;   // REG_CMD is write only
        endcase
    end

endmodule

/* source/eeprom_ctrl.sv */
`timescale 1ns/10ps

module eeprom_ctrl (
    input  logic      CLK,
    input  logic      RESET,
    reg_ctl_if.ctrl   ctl,
    i2c_cmd_if.master bus
);
    import eeprom_pkg::*;

    ctrl_state_t  state;
    ctrl_state_t  nxt;
    logic         is_read;
    logic         nack_q;
    logic         start;
    eeprom_addr_t addr_q;
    byte_t        wdata_q;
    byte_t        rdata_q;

    assign start = (state == IDLE) && (ctl.start_wr || ctl.start_rd);

    always_comb
    begin
        nxt = state;
        case (state)
            IDLE:    if (start) nxt = START;
            START:   if (bus.cmd_done) nxt = CTRL_W;
            CTRL_W:  if (bus.cmd_done) nxt = bus.ack_ok ? ADDR : STOP;
            ADDR:
                if (bus.cmd_done)
                begin
                    if (!bus.ack_ok)
                        nxt = STOP;
                    else
                        nxt = is_read ? RESTART : DATA_W;   // dummy write then read
                end
            DATA_W:  if (bus.cmd_done) nxt = STOP;
            RESTART: if (bus.cmd_done) nxt = CTRL_R;
            CTRL_R:  if (bus.cmd_done) nxt = bus.ack_ok ? DATA_R : STOP;
            DATA_R:  if (bus.cmd_done) nxt = STOP;
            STOP:    if (bus.cmd_done) nxt = FINISH;
            FINISH:  nxt = IDLE;
            default: nxt = IDLE;
        endcase
    end

    always_comb
    begin
        case (state)
            START:   bus.cmd = CMD_START;
            RESTART: bus.cmd = CMD_RESTART;
            DATA_R:  bus.cmd = CMD_READ_NACK;
            STOP:    bus.cmd = CMD_STOP;
            default: bus.cmd = CMD_WRITE;
        endcase
        case (state)
            CTRL_W:  bus.tx_byte = {DEVICE_CODE, addr_q[10:8], 1'b0};
            ADDR:    bus.tx_byte = addr_q[7:0];
            CTRL_R:  bus.tx_byte = {DEVICE_CODE, addr_q[10:8], 1'b1};
            default: bus.tx_byte = wdata_q;
        endcase
    end

    assign bus.cmd_valid = (state != IDLE) && (state != FINISH);
    assign ctl.busy      = (state != IDLE);
    assign ctl.finish    = (state == FINISH);
    assign ctl.nack_seen = nack_q;
    assign ctl.rdata     = rdata_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= IDLE;
            is_read <= 1'b0;
            nack_q  <= 1'b0;
        end
        else
        begin
            state <= nxt;
            if (start)
            begin
                is_read <= !ctl.start_wr;
                nack_q  <= 1'b0;
            end
            else if (bus.cmd_done && (bus.cmd == CMD_WRITE) && !bus.ack_ok)
                nack_q <= 1'b1;   // slave left SDA high
        end
    end

    // request captured so the registers may change meanwhile
    always_ff @(posedge CLK)
    begin
        if (start)
        begin
            addr_q  <= ctl.addr;
            wdata_q <= ctl.wdata;
        end
        if ((state == DATA_R) && bus.cmd_done)
            rdata_q <= bus.rx_byte;
    end

endmodule

/* source/i2c_bit_engine.sv */
`timescale 1ns/10ps

module i2c_bit_engine (
    input  logic      CLK,
    input  logic      RESET,
    i2c_cmd_if.engine bus,
    output logic      scl,
    input  logic      sda_in,
    output logic      sda_oe
);
    import eeprom_pkg::*;

    localparam int QW = $clog2(SCL_QUARTER);
    localparam logic [QW-1:0] QMAX = QW'(SCL_QUARTER - 1);

    logic          active;
    i2c_cmd_t      cmd_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;      // 0 low, 1-2 high, 3 low for data bits
    logic [3:0]    bitn;       // bit 8 is the ack slot
    byte_t         sh;
    logic          ack_q;
    logic          boundary;
    logic          last;
    logic          sample;
    logic [1:0]    nxt_phase;
    logic [3:0]    nxt_bit;
    byte_t         nxt_sh;

    // {scl, sda pull} for a given phase of a command
    function automatic logic [1:0] bus_level(input i2c_cmd_t c, input logic [1:0] ph,
                                             input logic [3:0] bn, input logic d);
        logic       hi;
        logic [1:0] lvl;
        hi = (ph == 2'd1) || (ph == 2'd2);
        case (c)
            CMD_START:   lvl = {ph != 2'd3, ph[1]};   // sda falls in phase 2
            CMD_RESTART: lvl = {hi, ph[1]};
            CMD_STOP:    lvl = {ph != 2'd0, ~ph[1]};  // sda rises in phase 2
            CMD_WRITE:   lvl = {hi, (bn < 4'd8) && !d};
            default:     lvl = {hi, 1'b0};            // read bits and the nack
        endcase
        return lvl;
    endfunction

    assign boundary  = active && (qcnt == QMAX);
    assign sample    = active && (qcnt == '0) && (phase == 2'd1);   // first scl high cycle
    assign last      = boundary && (phase == 2'd3) &&
                       (((cmd_q != CMD_WRITE) && (cmd_q != CMD_READ_NACK)) || (bitn == 4'd8));
    assign nxt_phase = phase + 2'd1;
    assign nxt_bit   = (phase == 2'd3) ? bitn + 4'd1 : bitn;
    assign nxt_sh    = ((cmd_q == CMD_WRITE) && (phase == 2'd3)) ? {sh[6:0], 1'b0} : sh;

    assign bus.cmd_done = last;
    assign bus.rx_byte  = sh;
    assign bus.ack_ok   = ack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            cmd_q  <= CMD_STOP;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitn   <= 4'd0;
            scl    <= 1'b1;   // bus idle
            sda_oe <= 1'b0;
            ack_q  <= 1'b0;
        end
        else if (!active)
        begin
            if (bus.cmd_valid)
            begin
                active <= 1'b1;
                cmd_q  <= bus.cmd;
                qcnt   <= '0;
                phase  <= 2'd0;
                bitn   <= 4'd0;
                {scl, sda_oe} <= bus_level(bus.cmd, 2'd0, 4'd0, bus.tx_byte[7]);
            end
        end
        else if (last)
            active <= 1'b0;   // lines hold until next command
        else
        begin
            qcnt <= qcnt + 1'b1;
            if (boundary)
            begin
                qcnt  <= '0;
                phase <= nxt_phase;
                bitn  <= nxt_bit;
                {scl, sda_oe} <= bus_level(cmd_q, nxt_phase, nxt_bit, nxt_sh[7]);
            end
            if (sample && (cmd_q == CMD_WRITE) && (bitn == 4'd8))
                ack_q <= !sda_in;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && bus.cmd_valid)
            sh <= bus.tx_byte;
        else if (sample && (cmd_q == CMD_READ_NACK) && (bitn < 4'd8))
            sh <= {sh[6:0], sda_in};   // msb first
        else if (boundary)
            sh <= nxt_sh;
    end

endmodule

/* source/eeprom_master_top.sv */
`timescale 1ns/10ps

module eeprom_master_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  eeprom_pkg::apb_addr_t paddr,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  scl,
    input  logic                  sda_in,
    output logic                  sda_oe     // high pulls sda low
);

    reg_ctl_if reg_ctl ();
    i2c_cmd_if i2c_cmd ();

    apb_regs apb_regs_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctl     (reg_ctl.regs)
    );

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK   (CLK),
        .RESET (RESET),
        .ctl   (reg_ctl.ctrl),
        .bus   (i2c_cmd.master)
    );

    i2c_bit_engine i2c_bit_engine_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .bus    (i2c_cmd.engine),
        .scl    (scl),
        .sda_in (sda_in),
        .sda_oe (sda_oe)
    );

endmodule

/* test/eeprom_model.sv */
`timescale 1ns/10ps

module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic ignore_addr,   // no ack for the control byte
    output logic sda_pull
);
    typedef enum {M_IDLE, M_DEV, M_ADDR, M_WDATA, M_RDATA} mode_t;

    logic [7:0]  mem [0:2047];
    mode_t       mode = M_IDLE;
    int          bitc = 0;
    logic [7:0]  sr = 8'h00;
    logic [7:0]  rd_sh = 8'h00;
    logic [10:0] ptr = 11'h000;    // current address pointer
    logic        ack_pend = 1'b0;
    logic        scl_d = 1'b1;
    logic        sda_d = 1'b1;

    initial
    begin
        sda_pull = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
    end

    // start and stop only when scl stays high
    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_d === 1'b1 && sda_d === 1'b1 && sda === 1'b0)
        begin
            mode     = M_DEV;
            bitc     = 0;
            ack_pend = 1'b0;
        end
        else if (scl === 1'b1 && scl_d === 1'b1 && sda_d === 1'b0 && sda === 1'b1)
        begin
            mode     = M_IDLE;
            bitc     = 0;
            ack_pend = 1'b0;
        end
        else if (scl === 1'b1 && scl_d === 1'b0 && mode != M_IDLE)
        begin
            if (bitc < 8)
            begin
                if (mode != M_RDATA)
                    sr = {sr[6:0], sda};
                bitc = bitc + 1;
                if (bitc == 8)
                begin
                    ack_pend = 1'b1;
                    case (mode)
                        M_DEV:
                            if (ignore_addr || sr[7:4] != 4'b1010)
                            begin
                                ack_pend = 1'b0;
                                mode     = M_IDLE;
                            end
                            else if (sr[0])
                            begin
                                mode  = M_RDATA;
                                rd_sh = mem[ptr];
                            end
                            else
                            begin
                                ptr[10:8] = sr[3:1];
                                mode      = M_ADDR;
                            end
                        M_ADDR:
                        begin
                            ptr[7:0] = sr;
                            mode     = M_WDATA;
                        end
                        M_WDATA:
                        begin
                            mem[ptr] = sr;
                            ptr      = ptr + 11'd1;
                        end
                        default: ack_pend = 1'b0;   // master acks a read byte
                    endcase
                end
            end
            else
            begin
                bitc = 0;
                if (mode == M_RDATA && !ack_pend)   // ack slot after a data byte
                begin
                    ptr = ptr + 11'd1;
                    if (sda)
                        mode = M_IDLE;   // nack from master
                    else
                        rd_sh = mem[ptr];
                end
            end
        end
        else if (scl === 1'b0 && scl_d === 1'b1)
        begin
            if (bitc == 8)
                sda_pull = ack_pend;
            else if (mode == M_RDATA)
                sda_pull = !rd_sh[7 - bitc];
            else
                sda_pull = 1'b0;
        end
        scl_d = scl;
        sda_d = sda;
    end

endmodule

/* test/eeprom_master_assertions.sv */
`timescale 1ns/10ps

module eeprom_master_assertions (
    input logic                 CLK,
    input logic                 RESET,
    input logic                 scl,
    input logic                 sda_oe,
    input eeprom_pkg::i2c_cmd_t cmd,
    input logic                 cmd_valid,
    input logic                 cmd_done
);
    import eeprom_pkg::*;

    // sda may move under a high scl only for start, restart and stop
    sda_stable_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_oe != $past(sda_oe)))
            |-> (cmd inside {CMD_START, CMD_RESTART, CMD_STOP}))
        else $error("sda changed while scl high outside start or stop");

    done_needs_valid: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |-> cmd_valid)
        else $error("cmd_done without cmd_valid");

    released_after_reset: assert property (@(posedge CLK) $past(RESET) |-> !sda_oe)
        else $error("sda_oe high right after reset");

endmodule

bind i2c_bit_engine eeprom_master_assertions bus_checks (
    .CLK       (CLK),
    .RESET     (RESET),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .cmd       (cmd_q),
    .cmd_valid (bus.cmd_valid),
    .cmd_done  (bus.cmd_done)
);

/* test/tb_eeprom_master.sv */
`timescale 1ns/10ps

module tb_eeprom_master;
    import eeprom_pkg::*;

    localparam longint NUM_OPS = 46;   // transactions in the whole run

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    logic        slave_pull;
    logic        ignore_addr;
    logic [31:0] lfsr;
    logic [7:0]  ref_mem [0:2047];
    int          errors;

    assign sda = !(sda_oe || slave_pull);   // open drain with pull-up

    eeprom_master_top eeprom_master_top_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_in  (sda),
        .sda_oe  (sda_oe)
    );

    eeprom_model eeprom_model_inst (
        .scl         (scl),
        .sda         (sda),
        .ignore_addr (ignore_addr),
        .sda_pull    (slave_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial
    begin
        #((NUM_OPS * 1200 + 16) * 8);
        $display("timeout: the transactions did not finish in the allowed time");
        $display("Done: errors found");
        $finish;
    end

    // galois lfsr, one step per bit taken
    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] a, input logic [31:0] d,
                            output logic [31:0] rd, output logic err);
        @(posedge CLK);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(posedge CLK);
        #1;
        penable = 1'b1;
        #2;
        rd  = prdata;   // mid cycle, settled
        err = pslverr;
        check_value("pready", 32'd1, {31'd0, pready});
        @(posedge CLK);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input string name, input logic [3:0] a, input logic [31:0] d);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, a, d, rd, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic reg_read(input string name, input logic [3:0] a, output logic [31:0] rd);
        logic err;
        apb_xfer(1'b0, a, 32'd0, rd, err);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic wait_done(input string name, output logic [2:0] status);
        logic [31:0] rd;
        logic        err;
        time         t0;
        t0 = $time;
        status = 3'b000;
        do
        begin
            apb_xfer(1'b0, REG_STATUS, 32'd0, rd, err);
            status = rd[2:0];
        end
        while (!status[1] && ($time - t0 < 1200 * 8));
        assert (status[1])
        else
        begin
            errors++;
            $display("%s: done never came within 1200 cycles", name);
        end
    endtask

    task automatic do_write(input string name, input logic [10:0] a, input logic [7:0] d);
        logic [2:0] status;
        reg_write(name, REG_ADDR, {21'd0, a});
        reg_write(name, REG_DATA, {24'd0, d});
        reg_write(name, REG_CMD, 32'd1);
        wait_done(name, status);
        check_value({name, " status"}, 32'd2, {29'd0, status});
        if (status == 3'b010)
            ref_mem[a] = d;
    endtask

    task automatic do_read(input string name, input logic [10:0] a);
        logic [2:0]  status;
        logic [31:0] rd;
        reg_write(name, REG_ADDR, {21'd0, a});
        reg_write(name, REG_CMD, 32'd2);
        wait_done(name, status);
        check_value({name, " status"}, 32'd2, {29'd0, status});
        reg_read(name, REG_DATA, rd);
        check_value({name, " data"}, {24'd0, ref_mem[a]}, rd);
    endtask

    initial
    begin
        logic [31:0] rd;
        logic        err;
        logic [2:0]  status;
        logic [10:0] a;
        logic [7:0]  d;

        RESET       = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = 4'h0;
        pwdata      = 32'd0;
        ignore_addr = 1'b0;
        errors      = 0;
        lfsr        = 32'h8d45e3c8;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;   // same fill as the slave
        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;

        check_value("reset scl", 32'd1, {31'd0, scl});
        check_value("reset sda_oe", 32'd0, {31'd0, sda_oe});
        reg_read("reset status", REG_STATUS, rd);
        check_value("reset status", 32'd0, rd);

        reg_write("addr readback", REG_ADDR, 32'h5a3);
        reg_read("addr readback", REG_ADDR, rd);
        check_value("addr readback", 32'h5a3, rd);
        reg_write("data readback", REG_DATA, 32'hc7);
        reg_read("data readback", REG_DATA, rd);
        check_value("data readback", 32'hc7, rd);

        do_write("write then read", 11'h2b4, 8'h3c);
        do_read("write then read", 11'h2b4);

        for (int n = 0; n < 40; n++)
        begin
            if (take_bits(1) == 32'd1)
            begin
                a = 11'(take_bits(11));
                d = 8'(take_bits(8));
                do_write("random write", a, d);
            end
            else
            begin
                a = 11'(take_bits(11));
                do_read("random read", a);
            end
        end

        // refused command and unknown offset while a write runs
        reg_write("busy write", REG_ADDR, 32'h07f);
        reg_write("busy write", REG_DATA, 32'h96);
        reg_write("busy write", REG_CMD, 32'd1);
        apb_xfer(1'b1, REG_CMD, 32'd2, rd, err);
        check_value("cmd while busy pslverr", 32'd1, {31'd0, err});
        apb_xfer(1'b0, 4'h2, 32'd0, rd, err);
        check_value("unknown offset pslverr", 32'd1, {31'd0, err});
        wait_done("busy write", status);
        check_value("busy write status", 32'd2, {29'd0, status});
        if (status == 3'b010)
            ref_mem[11'h07f] = 8'h96;
        do_read("busy write", 11'h07f);

        ignore_addr = 1'b1;
        reg_write("nack", REG_ADDR, 32'h3e1);
        reg_write("nack", REG_DATA, {24'd0, ~ref_mem[11'h3e1]});
        reg_write("nack", REG_CMD, 32'd1);
        wait_done("nack", status);
        check_value("nack status", 32'd6, {29'd0, status});
        check_value("nack memory", {24'd0, ref_mem[11'h3e1]},
                    {24'd0, eeprom_model_inst.mem[11'h3e1]});
        ignore_addr = 1'b0;
        do_read("nack", 11'h3e1);   // master recovers, old byte still there

        $display("error count: %0d", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* sim.f */
source/eeprom_pkg.sv
source/eeprom_ifs.sv
source/apb_regs.sv
source/eeprom_ctrl.sv
source/i2c_bit_engine.sv
source/eeprom_master_top.sv
test/eeprom_model.sv
test/eeprom_master_assertions.sv
test/tb_eeprom_master.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM master testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f sim.f --top-module tb_eeprom_master -o sim_bin
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_bin)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1
